/* source/routerPkg.sv */
`default_nettype none

package routerPkg;

  // --------------------------------------------------------------------------
  // Port numbering and sizes
  // --------------------------------------------------------------------------

  localparam int numPorts = 5;
  localparam int portIdxWidth = 3;

  localparam int portL = 0;
  localparam int portN = 1;
  localparam int portE = 2;
  localparam int portW = 3;
  localparam int portS = 4;

  localparam int queueDepth = 8;

  // --------------------------------------------------------------------------
  // Flit formats
  // --------------------------------------------------------------------------

  localparam int flitWidth = 16;
  localparam int lengthWidth = 12;

  localparam logic [2:0] flitKindHead = 3'b001;
  localparam logic [2:0] flitKindBody = 3'b010;

  // The length counts the body flits that follow the head.
  typedef struct packed {
    logic [2:0] kind;
    logic spare;
    logic [lengthWidth-1:0] length;
  } flitHead_t;

  typedef struct packed {
    logic [2:0] kind;
    logic [flitWidth-4:0] payload;
  } flitBody_t;

  typedef union packed {
    flitHead_t head;
    flitBody_t body;
  } flit_t;

  // The grant state is one-hot. Bit 0 is idle and bit p+1 is port p.
  typedef enum logic [5:0] {
    stateIdle = 6'b000001,
    stateL    = 6'b000010,
    stateN    = 6'b000100,
    stateE    = 6'b001000,
    stateW    = 6'b010000,
    stateS    = 6'b100000
  } grantState_t;

endpackage

`default_nettype wire

/* source/portRequestIf.sv */
`default_nettype none

// Requests and head flits flow toward the arbiter, pops flow back.
interface portRequestIf;

  logic [routerPkg::numPorts-1:0] req;
  routerPkg::flit_t [routerPkg::numPorts-1:0] headFlit;
  logic [routerPkg::numPorts-1:0] pop;

  modport queue (
    output req,
    output headFlit,
    input  pop
  );

  modport arbiter (
    input  req,
    input  headFlit,
    output pop
  );

endinterface

`default_nettype wire

/* source/flitQueue.sv */
`default_nettype none

module flitQueue #(
  parameter int depth = routerPkg::queueDepth
) (
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  routerPkg::flit_t pushFlit,
  output logic full,
  output logic req,
  output routerPkg::flit_t headFlit,
  input  logic pop
);

  routerPkg::flit_t mem [depth];

  logic [$clog2(depth)-1:0] rdPtr;
  logic [$clog2(depth)-1:0] wrPtr;
  logic [$clog2(depth+1)-1:0] count;

  assign req = (count != '0);
  assign full = (int'(count) == depth);
  assign headFlit = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wrPtr] <= pushFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
      begin
        wrPtr <= (int'(wrPtr) == depth - 1) ? '0 : wrPtr + 1'b1;
      end
      if (pop)
      begin
        rdPtr <= (int'(rdPtr) == depth - 1) ? '0 : rdPtr + 1'b1;
      end
      // Simultaneous push and pop leaves the occupancy unchanged.
      case ({push, pop})
        2'b10:
        begin
          count <= count + 1'b1;
        end
        2'b01:
        begin
          count <= count - 1'b1;
        end
        default:
        begin
          count <= count;
        end
      endcase
    end
  end

  // The source must hold off while full rises.
  pushWhileFull: assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else $error("flitQueue: push into a full queue");

  // The arbiter only pops a port that requests.
  popWhileEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> req)
    else $error("flitQueue: pop from an empty queue");

endmodule

`default_nettype wire

/* source/packetTimer.sv */
`default_nettype none

module packetTimer (
  input  logic clk,
  input  logic rst,
  input  logic pop,
  input  routerPkg::flit_t headFlit,
  input  logic hold,
  output logic timesUp
);

  logic [routerPkg::lengthWidth-1:0] limit;
  logic [routerPkg::lengthWidth-1:0] count;
  logic active;
  logic headPop;

  assign headPop = pop && (headFlit.head.kind == routerPkg::flitKindHead);

  // The head flit goes out first, then one body flit per count step.
  assign timesUp = active && (count == limit);

  always_ff @(posedge clk)
  begin
    if (headPop)
    begin
      limit <= headFlit.head.length;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      active <= 1'b0;
      count <= '0;
    end
    else if (!hold)
    begin
      active <= 1'b0;
      count <= '0;
    end
    else if (headPop)
    begin
      active <= 1'b1;
      count <= '0;
    end
    else
    begin
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* source/switchArbiter.sv */
`default_nettype none

module switchArbiter (
  input  logic clk,
  input  logic rst,
  portRequestIf.arbiter reqs,
  output logic grantValid,
  output logic [routerPkg::portIdxWidth-1:0] grantPort,
  output routerPkg::flit_t grantFlit
);

  routerPkg::grantState_t state;
  routerPkg::grantState_t nextState;

  logic [5:0] stateBits;
  logic [routerPkg::numPorts-1:0] granted;
  logic [routerPkg::numPorts-1:0] timesUp;
  logic [routerPkg::numPorts-1:0] popVec;
  logic curActive;
  logic [routerPkg::portIdxWidth-1:0] curPort;

  // --------------------------------------------------------------------------
  // Packet timers, one per input port
  // --------------------------------------------------------------------------

  for (genvar gi = 0; gi < routerPkg::numPorts; gi++)
  begin : genTimer
    packetTimer timerInst (
      .clk     (clk),
      .rst     (rst),
      .pop     (popVec[gi]),
      .headFlit(reqs.headFlit[gi]),
      .hold    (granted[gi]),
      .timesUp (timesUp[gi])
    );
  end

  // --------------------------------------------------------------------------
  // Grant decode
  // --------------------------------------------------------------------------

  assign stateBits = state;
  assign granted = stateBits[routerPkg::numPorts:1];
  assign curActive = (state != routerPkg::stateIdle);

  // A port keeps the grant while it requests and its packet is not done.
  assign popVec = granted & reqs.req & ~timesUp;
  assign reqs.pop = popVec;
  assign grantValid = |popVec;

  always_comb
  begin
    curPort = '0;
    for (int p = 0; p < routerPkg::numPorts; p++)
    begin
      if (granted[p])
      begin
        curPort = routerPkg::portIdxWidth'(p);
      end
    end
  end

  assign grantPort = curPort;
  assign grantFlit = reqs.headFlit[curPort];

  // --------------------------------------------------------------------------
  // Next state with rotating priority
  // --------------------------------------------------------------------------

  always_comb
  begin
    int scanBase;
    int cand;
    scanBase = curActive ? int'(curPort) + 1 : routerPkg::portL;
    cand = 0;
    nextState = routerPkg::stateIdle;
    if (grantValid)
    begin
      nextState = state;
    end
    else
    begin
      // Scan backwards so that the nearest requester in circular order wins.
      // The port that just released is not a candidate.
      for (int k = routerPkg::numPorts - 1; k >= 0; k--)
      begin
        cand = (scanBase + k) % routerPkg::numPorts;
        if (reqs.req[cand] && !(curActive && cand == int'(curPort)))
        begin
          nextState = routerPkg::grantState_t'(6'b000010 << cand);
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= routerPkg::stateIdle;
    end
    else
    begin
      state <= nextState;
    end
  end

  stateOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(stateBits))
    else $error("switchArbiter: grant state is not one-hot");

endmodule

`default_nettype wire

/* source/egressStage.sv */
`default_nettype none

module egressStage (
  input  logic clk,
  input  logic rst,
  input  logic grantValid,
  input  logic [routerPkg::portIdxWidth-1:0] grantPort,
  input  routerPkg::flit_t grantFlit,
  output logic outValid,
  output logic [routerPkg::portIdxWidth-1:0] outPort,
  output routerPkg::flit_t outFlit
);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= grantValid;
    end
  end

  // Port and flit only change on a granted cycle.
  always_ff @(posedge clk)
  begin
    if (grantValid)
    begin
      outPort <= grantPort;
      outFlit <= grantFlit;
    end
  end

  validPort: assert property (@(posedge clk) disable iff (rst)
    outValid |-> (int'(outPort) < routerPkg::numPorts))
    else $error("egressStage: output port out of range");

endmodule

`default_nettype wire

/* source/routerOutputPort.sv */
`default_nettype none

module routerOutputPort (
  input  logic clk,
  input  logic rst,
  input  logic [routerPkg::numPorts-1:0] push,
  input  logic [routerPkg::numPorts-1:0][routerPkg::flitWidth-1:0] pushFlit,
  output logic outValid,
  output logic [routerPkg::portIdxWidth-1:0] outPort,
  output logic [routerPkg::flitWidth-1:0] outFlit,
  output logic [routerPkg::numPorts-1:0] full
);

  portRequestIf reqBus ();

  logic grantValid;
  logic [routerPkg::portIdxWidth-1:0] grantPort;
  routerPkg::flit_t grantFlit;

  // Input queues, one per port in the order L, N, E, W, S.
  for (genvar gi = 0; gi < routerPkg::numPorts; gi++)
  begin : genQueue
    flitQueue #(
      .depth(routerPkg::queueDepth)
    ) queueInst (
      .clk     (clk),
      .rst     (rst),
      .push    (push[gi]),
      .pushFlit(pushFlit[gi]),
      .full    (full[gi]),
      .req     (reqBus.req[gi]),
      .headFlit(reqBus.headFlit[gi]),
      .pop     (reqBus.pop[gi])
    );
  end

  switchArbiter arbiterInst (
    .clk       (clk),
    .rst       (rst),
    .reqs      (reqBus.arbiter),
    .grantValid(grantValid),
    .grantPort (grantPort),
    .grantFlit (grantFlit)
  );

  egressStage egressInst (
    .clk       (clk),
    .rst       (rst),
    .grantValid(grantValid),
    .grantPort (grantPort),
    .grantFlit (grantFlit),
    .outValid  (outValid),
    .outPort   (outPort),
    .outFlit   (outFlit)
  );

endmodule

`default_nettype wire

/* bench/routerOutputPortTb.sv */
`default_nettype none

module routerOutputPortTb;

  localparam int numPorts = routerPkg::numPorts;
  localparam int depth = routerPkg::queueDepth;

  logic clk;
  logic rst;
  logic [numPorts-1:0] push;
  logic [numPorts-1:0][15:0] pushFlit;
  logic outValid;
  logic [2:0] outPort;
  logic [15:0] outFlit;
  logic [numPorts-1:0] full;

  int seed = 70276;
  string testName = "reset";

  // Model state holds the flits sent per port and still owed by the DUT.
  logic [15:0] sentQ [numPorts][$];
  int pendingLen [numPorts][$];
  int randLen [numPorts][$];
  int pktLeft [numPorts];
  int seqNum [numPorts];
  int pushedCount [numPorts];
  int deliveredCount [numPorts];
  int pushedTotal;
  int deliveredTotal;
  int cycleCount;
  int cycleLimit;
  int firstPushEdge = 1 << 30;
  bit randomStart;
  int bodyLeft;
  int pktPort;
  bit rotationDue;
  bit [numPorts-1:0] reqSnap;

  routerOutputPort dut0 (
    .clk     (clk),
    .rst     (rst),
    .push    (push),
    .pushFlit(pushFlit),
    .outValid(outValid),
    .outPort (outPort),
    .outFlit (outFlit),
    .full    (full)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #2 clk = ~clk;
    end
  end

  // ---------------------------------------------------------------------------
  // Flit building and reference model
  // ---------------------------------------------------------------------------

  function automatic logic [15:0] makeHead(input int len);
    return {routerPkg::flitKindHead, 1'b0, 12'(len)};
  endfunction

  // Payload carries the port in its top bits and a sequence number below.
  function automatic logic [15:0] makeBody(input int p, input int seq);
    return {routerPkg::flitKindBody, 3'(p), 10'(seq)};
  endfunction

  function automatic logic [15:0] expectedFlit(input int p);
    return sentQ[p][0];
  endfunction

  // First port after the released one, in the order L, N, E, W, S, that had flits queued.
  function automatic int nextRequester(input int from);
    for (int k = 1; k < numPorts; k++)
      if (reqSnap[(from + k) % numPorts])
        return (from + k) % numPorts;
    return from;
  endfunction

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic valueError(input string what, input logic [15:0] expected,
                            input logic [15:0] actual);
    failRun($sformatf("[ERROR] %s: %s expected %0h actual %0h", testName, what, expected,
                      actual));
  endtask

  // ---------------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------------

  task automatic sendFlit(input int p, input logic [15:0] flit);
    assert (!full[p]) else failRun($sformatf("push on port %0d while its queue is full", p));
    push[p] = 1'b1;
    pushFlit[p] = flit;
    sentQ[p].push_back(flit);
    pushedCount[p]++;
    pushedTotal++;
    if (firstPushEdge == (1 << 30))
      firstPushEdge = cycleCount + 1;
  endtask

  // A packet starts only when the whole of it fits, then goes out one flit per cycle.
  task automatic driveCycle();
    int len;
    for (int p = 0; p < numPorts; p++)
    begin
      push[p] = 1'b0;
      if (pktLeft[p] > 0)
      begin
        sendFlit(p, makeBody(p, seqNum[p]));
        seqNum[p]++;
        pktLeft[p]--;
      end
      else if (pendingLen[p].size() > 0 && (!randomStart || ($random(seed) & 3) == 0))
      begin
        len = pendingLen[p][0];
        if (depth - (pushedCount[p] - deliveredCount[p]) >= len + 1)
        begin
          void'(pendingLen[p].pop_front());
          sendFlit(p, makeHead(len));
          pktLeft[p] = len;
        end
      end
    end
  endtask

  task automatic runPhase(input string name, input bit randomized);
    bit busy;
    testName = name;
    randomStart = randomized;
    busy = 1'b1;
    while (busy)
    begin
      @(negedge clk);
      driveCycle();
      busy = 1'b0;
      for (int p = 0; p < numPorts; p++)
        busy |= (pendingLen[p].size() > 0) || (pktLeft[p] > 0);
    end
    @(negedge clk);
    push = '0;
    while (deliveredTotal != pushedTotal)
      @(negedge clk);
  endtask

  // ---------------------------------------------------------------------------
  // Checker
  // ---------------------------------------------------------------------------

  task automatic checkFlit();
    int p;
    logic [15:0] expected;
    p = int'(outPort);
    assert (p < numPorts && sentQ[p].size() > 0)
    else failRun($sformatf("flit delivered on port %0d with nothing pending there", p));
    expected = expectedFlit(p);
    assert (outFlit === expected) else valueError("per-port order", expected, outFlit);
    void'(sentQ[p].pop_front());
    deliveredCount[p]++;
    deliveredTotal++;
    if (bodyLeft > 0)
    begin
      assert (p == pktPort) else valueError("packet contiguity", 16'(pktPort), 16'(p));
      bodyLeft--;
    end
    else
    begin
      assert (outFlit[15:13] == routerPkg::flitKindHead)
      else valueError("head flit kind", 16'(routerPkg::flitKindHead), 16'(outFlit[15:13]));
      if (rotationDue)
      begin
        assert (p == nextRequester(pktPort))
        else valueError("rotation", 16'(nextRequester(pktPort)), 16'(p));
      end
      rotationDue = 1'b0;
      pktPort = p;
      bodyLeft = int'(outFlit[11:0]);
    end
    // After the last flit of a packet the model occupancy equals the arbiter's requests.
    if (bodyLeft == 0)
    begin
      for (int r = 0; r < numPorts; r++)
        reqSnap[r] = (pushedCount[r] != deliveredCount[r]);
      reqSnap[p] = 1'b0;
      rotationDue = (reqSnap != '0);
    end
  endtask

  always @(posedge clk)
  begin
    logic expectedFull;
    #1;
    cycleCount++;
    if (cycleCount >= cycleLimit)
      failRun("timeout: not all flits were delivered within the cycle limit");
    if (rst || cycleCount <= firstPushEdge + 1)
    begin
      assert (!outValid) else failRun("outValid rose before any flit could have passed");
    end
    if (outValid)
      checkFlit();
    // A queue is full exactly when the model holds depth flits there after this edge.
    for (int p = 0; p < numPorts; p++)
    begin
      expectedFull = ((pushedCount[p] - deliveredCount[p]) == depth);
      assert (full[p] === expectedFull)
      else valueError("queue full flag", 16'(expectedFull), 16'(full[p]));
    end
  end

  initial
  begin
    int total;
    int len;
    rst = 1'b1;
    push = '0;
    pushFlit = '0;
    total = 16 + numPorts * 5;
    for (int p = 0; p < numPorts; p++)
      for (int n = 0; n < 12; n++)
      begin
        len = $unsigned($random(seed)) % 5;
        randLen[p].push_back(len);
        total += len + 1;
      end
    cycleLimit = 4 * total + 200;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (int n = 0; n < 16; n++)
      pendingLen[routerPkg::portN].push_back(0);
    runPhase("zeroLengthStream", 1'b0);

    for (int p = 0; p < numPorts; p++)
      pendingLen[p].push_back(4);
    runPhase("allPortBurst", 1'b0);

    for (int p = 0; p < numPorts; p++)
      pendingLen[p] = randLen[p];
    runPhase("randomTraffic", 1'b1);

    repeat (20) @(negedge clk);
    if (deliveredTotal == total && pushedTotal == total)
    begin
      $display("RESULT: PASS");
      $finish;
    end
    else
      failRun("flits were left undelivered at the end of the run");
  end

endmodule

`default_nettype wire

/* flist.f */
source/routerPkg.sv
source/portRequestIf.sv
source/flitQueue.sv
source/packetTimer.sv
source/switchArbiter.sv
source/egressStage.sv
source/routerOutputPort.sv
bench/routerOutputPortTb.sv

/* run.sh */
#!/bin/sh
# Builds the router output port testbench with Verilator and runs it.
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f flist.f \
    --top-module routerOutputPortTb -Mdir obj_dir -o routerOutputPortTb \
  && ./obj_dir/routerOutputPortTb \
  || exit 1
